// File: filelist.f
common/cache_pkg.sv
common/way_ctrl_if.sv
cache_way/sync_ram.sv
cache_way/cache_way_store.sv
source/cache_ctrl_fsm.sv
source/refill_sequencer.sv
source/cache_lookup.sv
source/cache_top.sv
verif/cache_assertions.sv
verif/cache_tb.sv

// File: verif/cache_tb.sv
module cache_tb
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         DRIVE_DELAY     = 10;
    localparam int         NUM_TESTS       = 6;
    localparam int         CYCLES_PER_REQ  = 40;
    localparam int         REQS_PER_TEST   = 3;  // longest test issues three requests
    localparam int         TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_REQ * REQS_PER_TEST;
    localparam word_t      FILL_KEY        = 32'h5A5A0000;
    localparam logic [2:0] LINE_BURST_CODE = 3'd4;   // burst type of one full line
    localparam index_t     SET_IDX         = 8'h3C;  // all tests share this set

    logic         clk;
    logic         resetn;
    logic         valid;
    logic         op;
    index_t       index;
    tag_t         tag;
    offset_t      offset;
    strb_t        wstrb;
    word_t        wdata;
    logic         addr_ok;
    logic         data_ok;
    word_t        rdata;
    logic         rd_req;
    logic [2:0]   rd_type;
    word_t        rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    word_t        ret_data;
    logic         wr_req;
    logic [2:0]   wr_type;
    word_t        wr_addr;
    strb_t        wr_wstrb;
    logic [127:0] wr_data;
    logic         wr_rdy;

    word_t      shadow [word_t];   // memory words written back
    word_t      ref_mem [word_t];  // expected cpu view after stores
    int         rd_count = 0;
    int         wr_count = 0;
    word_t      last_rd_addr;
    logic [2:0] last_rd_type;
    word_t      last_wr_addr;
    logic [2:0] last_wr_type;
    line_t      last_wr_data;
    tag_t       tag_a, tag_b, tag_c, tag_d;

    cache_top #(.SETS(256)) UUT (.*);

    bind cache_top cache_assertions u_assertions (
        .clk     (clk),
        .resetn  (resetn),
        .state   (state),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rd_req  (rd_req),
        .wr_req  (wr_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    function automatic word_t mem_word(input word_t a);
        return shadow.exists(a) ? shadow[a] : a ^ FILL_KEY;
    endfunction

    function automatic word_t expected_word(input word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : a ^ FILL_KEY;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t r;
        r = old_w;
        for (int i = 0; i < 4; i++)
            if (strb[i])
                r[8*i +: 8] = new_w[8*i +: 8];
        return r;
    endfunction

    // one request from acceptance until the cache is idle again
    task automatic do_request(input op_e rq_op, input tag_t t, input index_t i,
                              input offset_t o, input strb_t s, input word_t d,
                              output word_t got, output int latency);
        word_t a;
        a = {t, i, o};
        if (addr_ok !== 1'b1)
            fail_run("addr_ok was low when a new request was due");
        valid  = 1'b1;
        op     = rq_op;
        tag    = t;
        index  = i;
        offset = o;
        wstrb  = s;
        wdata  = d;
        @(posedge clk);
        #DRIVE_DELAY valid = 1'b0;
        latency = 0;
        do
        begin
            @(negedge clk);
            latency++;
        end
        while (data_ok !== 1'b1);
        got = rdata;
        while (addr_ok !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        if (rq_op == OP_WRITE)
            ref_mem[a] = merge_bytes(expected_word(a), d, s);
    endtask

    task automatic read_and_check(input tag_t t, input index_t i, input offset_t o,
                                  input bit expect_hit);
        word_t got;
        int    latency;
        int    reads_before;
        reads_before = rd_count;
        do_request(OP_READ, t, i, o, '0, '0, got, latency);
        check_word("rdata", got, expected_word({t, i, o}));
        if (expect_hit)
        begin
            check_count("read hit latency", latency, 1);
            check_count("refill requests", rd_count, reads_before);
        end
        else
            check_count("refill requests", rd_count, reads_before + 1);
    endtask

    task automatic write_and_check(input tag_t t, input offset_t o, input strb_t s,
                                   input int refills);
        word_t got;
        int    latency;
        int    reads_before;
        reads_before = rd_count;
        do_request(OP_WRITE, t, SET_IDX, o, s, $urandom, got, latency);
        check_count("write latency", latency, 1);
        check_count("refill requests", rd_count, reads_before + refills);
    endtask

    task automatic reset_then_read_miss();
        @(negedge clk);
        if (addr_ok !== 1'b1 || data_ok !== 1'b0 || rd_req !== 1'b0 || wr_req !== 1'b0)
            fail_run("port levels after reset are not idle");
        @(posedge clk);
        #DRIVE_DELAY;
        read_and_check(tag_a, SET_IDX, 4'h8, 1'b0);  // fills way 0
        check_addr("rd_addr", last_rd_addr, {tag_a, SET_IDX, 4'h0});
        check_word("rd_type", word_t'(last_rd_type), word_t'(LINE_BURST_CODE));
    endtask

    task automatic repeat_read_hit();
        read_and_check(tag_a, SET_IDX, 4'h8, 1'b1);
    endtask

    task automatic write_hit_then_read();
        write_and_check(tag_a, 4'h4, 4'b0101, 0);
        read_and_check(tag_a, SET_IDX, 4'h4, 1'b1);
    endtask

    task automatic write_miss_then_read();
        write_and_check(tag_b, 4'h8, 4'b1100, 1);  // way 1 still invalid
        read_and_check(tag_b, SET_IDX, 4'h8, 1'b1);
    endtask

    task automatic hit_both_ways();
        read_and_check(tag_a, SET_IDX, 4'h0, 1'b1);
        read_and_check(tag_b, SET_IDX, 4'hC, 1'b1);
    endtask

    task automatic evict_dirty_line();
        int    writes_before;
        line_t exp_line;
        word_t base;
        writes_before = wr_count;
        base = {tag_a, SET_IDX, 4'h0};
        for (int w = 0; w < WORDS_PER_LINE; w++)
            exp_line[w] = expected_word(base + word_t'(4 * w));
        read_and_check(tag_c, SET_IDX, 4'hC, 1'b0);  // way 0 goes with both valid
        check_count("writebacks", wr_count, writes_before + 1);
        check_addr("wr_addr", last_wr_addr, base);
        check_word("wr_type", word_t'(last_wr_type), word_t'(LINE_BURST_CODE));
        check_line("wr_data", last_wr_data, exp_line);
        read_and_check(tag_d, SET_IDX, 4'h0, 1'b0);  // clean victim
        check_count("writebacks", wr_count, writes_before + 1);
        read_and_check(tag_a, SET_IDX, 4'h4, 1'b0);  // comes back from memory
    endtask

    // read burst after a ready delay of 0 to 3 cycles
    initial
    begin : read_port
        word_t base;
        @(posedge resetn);
        forever
        begin
            @(negedge clk);
            if (rd_req)
            begin
                base = rd_addr;
                rd_count++;
                last_rd_addr = rd_addr;
                last_rd_type = rd_type;
                repeat ($urandom % 4) @(posedge clk);
                @(posedge clk);
                #DRIVE_DELAY rd_rdy = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY rd_rdy = 1'b0;
                for (int b = 0; b < WORDS_PER_LINE; b++)
                begin
                    ret_valid = 1'b1;
                    ret_last  = b == WORDS_PER_LINE - 1;
                    ret_data  = mem_word(base + word_t'(4 * b));
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    // captures the writeback and stays busy for 0 to 3 cycles
    initial
    begin : write_port
        int busy;
        @(posedge resetn);
        forever
        begin
            @(negedge clk);
            if (wr_req)
            begin
                if (wr_wstrb !== 4'hF)
                    fail_run("writeback came without a full byte strobe");
                wr_count++;
                last_wr_addr = wr_addr;
                last_wr_type = wr_type;
                last_wr_data = wr_data;
                for (int w = 0; w < WORDS_PER_LINE; w++)
                    shadow[wr_addr + word_t'(4 * w)] = last_wr_data[w];
                busy = $urandom % 4;
                if (busy != 0)
                begin
                    @(posedge clk);
                    #DRIVE_DELAY wr_rdy = 1'b0;
                    repeat (busy) @(posedge clk);
                    #DRIVE_DELAY wr_rdy = 1'b1;
                end
            end
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (UUT.u_assertions.error_count != 0)
                fail_run("a protocol assertion on the DUT failed");
            if (cycles >= TIMEOUT_CYCLES)
                fail_run($sformatf("timeout, no finish after %0d cycles", cycles));
        end
    end

    initial
    begin : main
        void'($urandom(22));
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b1;
        tag_a     = tag_t'($urandom);
        tag_b     = tag_a + 20'd1;  // distinct tags in the same set
        tag_c     = tag_a + 20'd2;
        tag_d     = tag_a + 20'd3;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY resetn = 1'b1;
        reset_then_read_miss();
        repeat_read_hit();
        write_hit_then_read();
        write_miss_then_read();
        hit_both_ways();
        evict_dirty_line();
        @(posedge clk);
        if (UUT.u_assertions.error_count != 0)
            fail_run("a protocol assertion on the DUT failed");
        else
            $display("Everything OK");
        $finish;
    end

endmodule

// File: verif/cache_assertions.sv
module cache_assertions
    import cache_pkg::*;
(
    input logic         clk,
    input logic         resetn,
    input cache_state_e state,
    input logic         addr_ok,
    input logic         data_ok,
    input logic         rd_req,
    input logic         wr_req
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;  // polled by the testbench

    wr_req_single: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)
    else
    begin
        $error("wr_req high for two cycles in a row");
        error_count++;
    end

    rd_req_not_idle: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && addr_ok))
    else
    begin
        $error("rd_req and addr_ok high together");
        error_count++;
    end

    // no response while the line is still being fetched
    no_data_in_miss: assert property (@(posedge clk) disable iff (!resetn)
        $rose(data_ok) |-> !(state inside {S_MISS, S_REPLACE}))
    else
    begin
        $error("data_ok rose in S_MISS or S_REPLACE");
        error_count++;
    end

endmodule

// File: source/cache_top.sv
module cache_top
    import cache_pkg::*;
#(
    parameter int SETS = 256
)
(
    input  logic         clk,
    input  logic         resetn,
    // cpu side
    input  logic         valid,
    input  logic         op,      // 1 write, 0 read
    input  logic [7:0]   index,
    input  logic [19:0]  tag,
    input  logic [3:0]   offset,
    input  logic [3:0]   wstrb,
    input  logic [31:0]  wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [31:0]  rdata,
    // memory side
    output logic         rd_req,
    output logic [2:0]   rd_type,
    output logic [31:0]  rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  logic [31:0]  ret_data,
    output logic         wr_req,
    output logic [2:0]   wr_type,
    output logic [31:0]  wr_addr,
    output logic [3:0]   wr_wstrb,
    output logic [127:0] wr_data,
    input  logic         wr_rdy
);
    cache_state_e state;
    req_t         req;
    logic         capture_req;
    logic         cache_hit;
    logic         hit_way;
    word_t        load_word;
    logic         victim_way;
    logic         victim_dirty;
    line_t        victim_line;
    tag_t         victim_tag;
    logic         beat_match;
    line_t        way0_line;
    line_t        way1_line;
    tag_entry_t   way0_tag;
    tag_entry_t   way1_tag;
    logic         way0_dirty;
    logic         way1_dirty;

    way_ctrl_if way0_if ();
    way_ctrl_if way1_if ();

    cache_ctrl_fsm u_fsm (
        .clk, .resetn, .valid, .req, .cache_hit, .hit_way, .victim_dirty, .victim_way,
        .rd_rdy, .ret_valid, .ret_last, .wr_rdy, .state, .addr_ok, .rd_req, .wr_req,
        .capture_req,
        .way0 (way0_if.ctrl),
        .way1 (way1_if.ctrl)
    );

    cache_lookup u_lookup (
        .clk, .resetn, .capture_req, .state, .op, .index, .tag, .offset, .wstrb, .wdata,
        .way0_line, .way1_line, .way0_tag, .way1_tag, .way0_dirty, .way1_dirty,
        .req, .cache_hit, .hit_way, .load_word, .victim_way, .victim_dirty,
        .victim_line, .victim_tag
    );

    refill_sequencer u_refill (
        .clk, .resetn, .state, .req, .hit_way, .victim_way, .ret_valid, .ret_data,
        .beat_match,
        .way0 (way0_if.data),
        .way1 (way1_if.data)
    );

    cache_way_store #(.SETS(SETS)) u_way0 (
        .clk, .resetn,
        .ctrl      (way0_if.store),
        .line      (way0_line),
        .tag_entry (way0_tag),
        .dirty     (way0_dirty)
    );

    cache_way_store #(.SETS(SETS)) u_way1 (
        .clk, .resetn,
        .ctrl      (way1_if.store),
        .line      (way1_line),
        .tag_entry (way1_tag),
        .dirty     (way1_dirty)
    );

    // hit data in lookup, forwarded beat during refill
    assign data_ok = (state == S_LOOKUP && (cache_hit || req.op == OP_WRITE))
                  || (beat_match && req.op == OP_READ);
    assign rdata   = (state == S_REFILL) ? ret_data : load_word;

    assign rd_type  = BURST_LINE_TYPE;
    assign rd_addr  = {req.tag, req.index, 4'b0};  // line aligned
    assign wr_type  = BURST_LINE_TYPE;
    assign wr_addr  = {victim_tag, req.index, 4'b0};
    assign wr_wstrb = '1;
    assign wr_data  = victim_line;

endmodule

// File: source/cache_lookup.sv
module cache_lookup
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         capture_req,
    input  cache_state_e state,
    input  logic         op,
    input  index_t       index,
    input  tag_t         tag,
    input  offset_t      offset,
    input  strb_t        wstrb,
    input  word_t        wdata,
    input  line_t        way0_line,
    input  line_t        way1_line,
    input  tag_entry_t   way0_tag,
    input  tag_entry_t   way1_tag,
    input  logic         way0_dirty,
    input  logic         way1_dirty,
    output req_t         req,
    output logic         cache_hit,
    output logic         hit_way,
    output word_t        load_word,
    output logic         victim_way,
    output logic         victim_dirty,
    output line_t        victim_line,
    output tag_t         victim_tag
);
    req_t  cpu_req;
    req_t  req_q;
    logic  way0_hit;
    logic  way1_hit;
    beat_t word_sel;
    logic  victim_sel;  // chosen from current ram outputs

    assign cpu_req = '{
        op:     op_e'(op),
        index:  index,
        tag:    tag,
        offset: offset,
        wstrb:  wstrb,
        wdata:  wdata
    };

    always_ff @(posedge clk)
    begin
        if (capture_req)
            req_q <= cpu_req;
    end

    // in idle the incoming request addresses the rams directly
    assign req = (state == S_IDLE) ? cpu_req : req_q;

    assign way0_hit  = way0_tag.valid && way0_tag.tag == req_q.tag;
    assign way1_hit  = way1_tag.valid && way1_tag.tag == req_q.tag;
    assign cache_hit = way0_hit || way1_hit;
    assign hit_way   = way1_hit;

    assign word_sel  = req_q.offset[3:2];
    assign load_word = way1_hit ? way1_line[word_sel] : way0_line[word_sel];

    // invalid way 0, then invalid way 1, else way 0
    assign victim_sel = !way0_tag.valid ? 1'b0 :
                        !way1_tag.valid ? 1'b1 :
                                          1'b0;

    assign victim_line  = victim_sel ? way1_line     : way0_line;
    assign victim_tag   = victim_sel ? way1_tag.tag  : way0_tag.tag;
    assign victim_dirty = victim_sel ? way1_dirty    : way0_dirty;

    // ram outputs hold through replace, so the choice is stable
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            victim_way <= 1'b0;
        else if (state == S_REPLACE)
            victim_way <= victim_sel;
    end

endmodule

// File: source/refill_sequencer.sv
module refill_sequencer
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  cache_state_e state,
    input  req_t         req,
    input  logic         hit_way,
    input  logic         victim_way,
    input  logic         ret_valid,
    input  word_t        ret_data,
    output logic         beat_match,
    way_ctrl_if.data     way0,
    way_ctrl_if.data     way1
);
    beat_t beat;
    beat_t req_beat;
    logic  target_way;
    strb_t bank_strb [WORDS_PER_LINE];
    word_t byte_mask;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            beat <= '0;
        else if (state != S_REFILL)
            beat <= '0;  // starts at zero on entry
        else if (ret_valid)
            beat <= beat + 1'b1;
    end

    assign req_beat   = req.offset[3:2];
    assign beat_match = state == S_REFILL && ret_valid && beat == req_beat;
    assign target_way = (state == S_REFILL) ? victim_way : hit_way;

    always_comb
    begin
        for (int b = 0; b < WORDS_PER_LINE; b++)
        begin
            bank_strb[b] = '0;
            if (state == S_REFILL && ret_valid && beat == beat_t'(b))
                bank_strb[b] = '1;
            else if (state == S_LOOKUP && req.op == OP_WRITE && req_beat == beat_t'(b))
                bank_strb[b] = req.wstrb;  // write hit, gated by way enable
        end
        for (int b = 0; b < WORDS_PER_LINE; b++)
        begin
            way0.bank_wstrb[b] = target_way ? strb_t'(0) : bank_strb[b];
            way1.bank_wstrb[b] = target_way ? bank_strb[b] : strb_t'(0);
        end
    end

    assign byte_mask = {{8{req.wstrb[3]}}, {8{req.wstrb[2]}},
                        {8{req.wstrb[1]}}, {8{req.wstrb[0]}}};

    // store bytes go over the refilled word on a write miss
    always_comb
    begin
        if (state != S_REFILL)
            way0.word_in = req.wdata;
        else if (req.op == OP_WRITE && beat == req_beat)
            way0.word_in = (req.wdata & byte_mask) | (ret_data & ~byte_mask);
        else
            way0.word_in = ret_data;
    end

    assign way1.word_in = way0.word_in;

endmodule

// File: source/cache_ctrl_fsm.sv
module cache_ctrl_fsm
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  req_t         req,
    input  logic         cache_hit,
    input  logic         hit_way,
    input  logic         victim_dirty,
    input  logic         victim_way,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  logic         wr_rdy,
    output cache_state_e state,
    output logic         addr_ok,
    output logic         rd_req,
    output logic         wr_req,
    output logic         capture_req,
    way_ctrl_if.ctrl     way0,
    way_ctrl_if.ctrl     way1
);
    cache_state_e next_state;
    logic         first_replace;
    logic         victim_rd;
    logic         hit_wr;
    logic         refill_wr;
    logic [1:0]   hit_sel;     // per way, write hit
    logic [1:0]   refill_sel;  // per way, refill beat
    tag_entry_t   new_tag;
    logic         dirty_next;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
                if (valid)
                    next_state = S_LOOKUP;
            S_LOOKUP:
                next_state = cache_hit ? S_IDLE : S_MISS;
            S_MISS:
                if (wr_rdy)
                    next_state = S_REPLACE;
            S_REPLACE:
                if (rd_rdy)
                    next_state = S_REFILL;
            S_REFILL:
                if (ret_valid && ret_last)
                    next_state = S_IDLE;
            default:
                next_state = S_IDLE;
        endcase
    end

    // writeback may only go out in the first replace cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            first_replace <= 1'b0;
        else
            first_replace <= victim_rd;
    end

    assign addr_ok     = state == S_IDLE;
    assign capture_req = valid && addr_ok;
    assign rd_req      = state == S_REPLACE;
    assign wr_req      = first_replace && victim_dirty;

    assign victim_rd = state == S_MISS && wr_rdy;  // read both ways at req index
    assign hit_wr    = state == S_LOOKUP && cache_hit && req.op == OP_WRITE;
    assign refill_wr = state == S_REFILL && ret_valid;

    assign hit_sel    = hit_wr ? (hit_way ? 2'b10 : 2'b01) : 2'b00;
    assign refill_sel = refill_wr ? (victim_way ? 2'b10 : 2'b01) : 2'b00;

    assign new_tag    = '{tag: req.tag, valid: 1'b1};
    assign dirty_next = req.op == OP_WRITE;  // clean after a read refill

    assign way0.en       = capture_req || victim_rd || hit_sel[0] || refill_sel[0];
    assign way0.index    = req.index;
    assign way0.tag_we   = refill_sel[0] && ret_last;
    assign way0.tag_in   = new_tag;
    assign way0.dirty_we = hit_sel[0] || (refill_sel[0] && ret_last);
    assign way0.dirty_in = dirty_next;

    assign way1.en       = capture_req || victim_rd || hit_sel[1] || refill_sel[1];
    assign way1.index    = req.index;
    assign way1.tag_we   = refill_sel[1] && ret_last;
    assign way1.tag_in   = new_tag;
    assign way1.dirty_we = hit_sel[1] || (refill_sel[1] && ret_last);
    assign way1.dirty_in = dirty_next;

endmodule

// File: cache_way/cache_way_store.sv
module cache_way_store
    import cache_pkg::*;
#(
    parameter int SETS = 256
)
(
    input  logic       clk,
    input  logic       resetn,
    way_ctrl_if.store  ctrl,
    output line_t      line,
    output tag_entry_t tag_entry,
    output logic       dirty
);
    word_t           bank_dout [WORDS_PER_LINE];
    logic [SETS-1:0] dirty_bits;

    // one bank per word position, all read together
    for (genvar b = 0; b < WORDS_PER_LINE; b++)
    begin : g_bank
        sync_ram #(
            .entry_t (word_t),
            .SETS    (SETS)
        ) u_bank (
            .clk     (clk),
            .en      (ctrl.en),
            .we_mask (ctrl.bank_wstrb[b]),
            .addr    (ctrl.index),
            .din     (ctrl.word_in),
            .dout    (bank_dout[b])
        );
    end

    always_comb
    begin
        for (int b = 0; b < WORDS_PER_LINE; b++)
            line[b] = bank_dout[b];
    end

    sync_ram #(
        .entry_t (tag_entry_t),
        .SETS    (SETS)
    ) u_tag (
        .clk     (clk),
        .en      (ctrl.en),
        .we_mask (ctrl.tag_we),  // whole entry
        .addr    (ctrl.index),
        .din     (ctrl.tag_in),
        .dout    (tag_entry)
    );

    // dirty table: flops, so it can be cleared on reset
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            dirty_bits <= '0;
        else if (ctrl.dirty_we)
            dirty_bits[ctrl.index] <= ctrl.dirty_in;
    end

    assign dirty = dirty_bits[ctrl.index];  // combinational read

endmodule

// File: cache_way/sync_ram.sv
module sync_ram
    import cache_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  SETS    = 256,
    localparam int ENTRY_W = $bits(entry_t),
    localparam int MASK_W  = (ENTRY_W % 8 == 0) ? ENTRY_W / 8 : 1
)
(
    input  logic              clk,
    input  logic              en,
    input  logic [MASK_W-1:0] we_mask,  // byte lanes, or one bit for odd widths
    input  index_t            addr,
    input  entry_t            din,
    output entry_t            dout
);
    localparam int LANE_W = ENTRY_W / MASK_W;

    // cleared at power-up so valid bits start at zero
    entry_t             mem [SETS] = '{default: '0};
    logic [ENTRY_W-1:0] bit_mask;

    always_comb
    begin
        for (int i = 0; i < ENTRY_W; i++)
            bit_mask[i] = we_mask[i / LANE_W];
    end

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (|we_mask)
                mem[addr] <= entry_t'((mem[addr] & ~bit_mask) | (din & bit_mask));
            dout <= mem[addr];  // old contents on a write
        end
    end

endmodule

// File: common/way_ctrl_if.sv
interface way_ctrl_if
    import cache_pkg::*;
();

    logic       en;          // ram enable, read and write
    index_t     index;
    logic       tag_we;
    tag_entry_t tag_in;
    logic       dirty_we;
    logic       dirty_in;
    strb_t      bank_wstrb [WORDS_PER_LINE];  // one byte mask per bank
    word_t      word_in;     // shared by all banks

    modport ctrl (
        output en, index, tag_we, tag_in, dirty_we, dirty_in
    );

    modport data (
        output bank_wstrb, word_in
    );

    modport store (
        input en, index, tag_we, tag_in, dirty_we, dirty_in,
        input bank_wstrb, word_in
    );

endinterface

// File: common/cache_pkg.sv
package cache_pkg;

    localparam int WORDS_PER_LINE = 4;

    // rd_type / wr_type code for a whole-line burst
    localparam logic [2:0] BURST_LINE_TYPE = 3'd4;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  index_t;   // addr[11:4]
    typedef logic [19:0] tag_t;     // addr[31:12]
    typedef logic [3:0]  offset_t;  // byte within line
    typedef logic [1:0]  beat_t;    // word within line

    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        tag_t tag;
        logic valid;  // bit 0
    } tag_entry_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef struct packed {
        op_e     op;
        index_t  index;
        tag_t    tag;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } req_t;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_LOOKUP  = 3'd1,
        S_MISS    = 3'd2,
        S_REPLACE = 3'd3,
        S_REFILL  = 3'd4
    } cache_state_e;

endpackage
